//--- build.f
+incdir+include
source/rv32i_types.sv
source/mem_stage.sv
source/data_mem.sv
source/wb_stage.sv
source/regfile.sv
source/rv32i_mem_wb.sv
verif/tb_clock.sv
verif/rv32i_mem_wb_tb.sv

//--- verif/mem_wb_tests.txt
# name valid load_rf sel mem_rd mem_wr st_width rd alu_out rs2_data pc u_imm br_en expected check_reg
# all hex; sel 0 alu 1 br 2 uimm 3 pc+4 4 lw 5 lh 6 lhu 7 lb 8 lbu; st_width 0 byte 1 half 2 word
alu_x1       1 1 0 0 0 0 01 12345678 00000000 00000000 00000000 0 12345678 01
br_set_x2    1 1 1 0 0 0 02 ffffffff 00000000 00000000 00000000 1 00000001 02
uimm_x4      1 1 2 0 0 0 04 00000000 00000000 00000000 abcde000 0 abcde000 04
pc4_x5       1 1 3 0 0 0 05 00000000 00000000 00001ffc 00000000 0 00002000 05
pc4_wrap_x6  1 1 3 0 0 0 06 00000000 00000000 fffffffc 00000000 0 00000000 06
sw_100       1 0 0 0 1 2 00 00000100 cafef00d 00000000 00000000 0 00000000 01
lw_100_b2b   1 1 4 1 0 0 07 00000100 00000000 00000000 00000000 0 cafef00d 07
sb_200       1 0 0 0 1 0 00 00000200 ffffff81 00000000 00000000 0 00000000 07
sb_201       1 0 0 0 1 0 00 00000201 1234567f 00000000 00000000 0 00000000 07
sh_202       1 0 0 0 1 1 00 00000202 aaaa8001 00000000 00000000 0 00000000 07
sh_204       1 0 0 0 1 1 00 00000204 00007ffe 00000000 00000000 0 00000000 07
sb_206       1 0 0 0 1 0 00 00000206 000000c3 00000000 00000000 0 00000000 07
sb_207       1 0 0 0 1 0 00 00000207 5555553c 00000000 00000000 0 00000000 07
lw_200       1 1 4 1 0 0 08 00000200 00000000 00000000 00000000 0 80017f81 08
lb_200       1 1 7 1 0 0 09 00000200 00000000 00000000 00000000 0 ffffff81 09
lbu_200      1 1 8 1 0 0 0a 00000200 00000000 00000000 00000000 0 00000081 0a
lb_201       1 1 7 1 0 0 0b 00000201 00000000 00000000 00000000 0 0000007f 0b
lbu_201      1 1 8 1 0 0 10 00000201 00000000 00000000 00000000 0 0000007f 10
lb_202       1 1 7 1 0 0 0c 00000202 00000000 00000000 00000000 0 00000001 0c
lbu_202      1 1 8 1 0 0 0d 00000202 00000000 00000000 00000000 0 00000001 0d
lb_203       1 1 7 1 0 0 0e 00000203 00000000 00000000 00000000 0 ffffff80 0e
lbu_203      1 1 8 1 0 0 0f 00000203 00000000 00000000 00000000 0 00000080 0f
lh_200       1 1 5 1 0 0 11 00000200 00000000 00000000 00000000 0 00007f81 11
lhu_200      1 1 6 1 0 0 12 00000200 00000000 00000000 00000000 0 00007f81 12
lh_202       1 1 5 1 0 0 13 00000202 00000000 00000000 00000000 0 ffff8001 13
lhu_202      1 1 6 1 0 0 14 00000202 00000000 00000000 00000000 0 00008001 14
lw_204       1 1 4 1 0 0 15 00000204 00000000 00000000 00000000 0 3cc37ffe 15
lh_206       1 1 5 1 0 0 17 00000206 00000000 00000000 00000000 0 00003cc3 17
x0_write     1 1 0 0 0 0 00 55555555 00000000 00000000 00000000 0 55555555 00
bubble_x1    0 1 0 0 0 0 01 99999999 00000000 00000000 00000000 0 00000000 01
noload_x2    1 0 0 0 0 0 02 77777777 00000000 00000000 00000000 0 00000000 02
ovl_a_x10    1 1 0 0 0 0 0a 0000000a 00000000 00000000 00000000 0 0000000a 0a
ovl_b_x10    1 1 0 0 0 0 0a 0000000b 00000000 00000000 00000000 0 0000000b 0a
ovl_c_x11    1 1 0 0 0 0 0b 0000000c 00000000 00000000 00000000 0 0000000c 0a
ovl_d_x10    1 1 2 0 0 0 0a 00000000 00000000 00000000 0000d000 0 0000d000 0b
ovl_lw_x11   1 1 4 1 0 0 0b 00000100 00000000 00000000 00000000 0 cafef00d 0a

//--- verif/rv32i_mem_wb_tb.sv
`include "rv32i_consts.svh"

module rv32i_mem_wb_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 8;
    localparam int DRIVE_DELAY = 1;
    localparam int MAX_TESTS   = 64;

    logic clk, rst;
    logic valid, load_regfile, mem_read, mem_write, br_en;
    logic [3:0] regfilemux_sel;
    logic [1:0] store_width;
    logic [4:0] rd, rd_addr, wb_rd;
    logic [31:0] alu_out, rs2_data, pc, u_imm, rd_data, wb_data;
    logic wb_load;

    // test table, one entry per line of the test file
    string       names [MAX_TESTS];
    logic        t_valid [MAX_TESTS];
    logic        t_load [MAX_TESTS];
    logic [3:0]  t_sel [MAX_TESTS];
    logic        t_mrd [MAX_TESTS];
    logic        t_mwr [MAX_TESTS];
    logic [1:0]  t_width [MAX_TESTS];
    logic [4:0]  t_rd [MAX_TESTS];
    logic [31:0] t_alu [MAX_TESTS];
    logic [31:0] t_rs2 [MAX_TESTS];
    logic [31:0] t_pc [MAX_TESTS];
    logic [31:0] t_uimm [MAX_TESTS];
    logic        t_br [MAX_TESTS];
    logic [31:0] t_exp [MAX_TESTS];
    logic [4:0]  t_chk [MAX_TESTS];
    bit          t_bad [MAX_TESTS];

    // expected register contents
    logic [31:0] model [`NUM_REGS];
    int n_tests, pass_count, fail_count, format_errors;
    bit loaded;

    tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(4)) u_clock (.clk_o(clk), .rst_o(rst));

    rv32i_mem_wb dut (
        .clk_i(clk), .rst_i(rst), .valid_i(valid), .load_regfile_i(load_regfile),
        .regfilemux_sel_i(regfilemux_sel), .mem_read_i(mem_read), .mem_write_i(mem_write),
        .store_width_i(store_width), .rd_i(rd), .alu_out_i(alu_out), .rs2_data_i(rs2_data),
        .pc_i(pc), .u_imm_i(u_imm), .br_en_i(br_en), .rd_addr_i(rd_addr),
        .rd_data_o(rd_data), .wb_load_o(wb_load), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
    );

    task automatic load_tests(output bit ok);
        int    fd;
        int    cnt;
        string line;
        string first;
        ok = 1'b0;
        n_tests = 0;
        fd = $fopen("verif/mem_wb_tests.txt", "r");
        if (fd == 0) return;
        ok = 1'b1;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip blank and comment lines
            if ($sscanf(line, "%s", first) < 1) continue;
            if (first.substr(0, 0) == "#") continue;
            if (n_tests == MAX_TESTS) begin
                $display("test table is full, line %s was skipped", first);
                format_errors++;
                continue;
            end
            cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          names[n_tests], t_valid[n_tests], t_load[n_tests], t_sel[n_tests],
                          t_mrd[n_tests], t_mwr[n_tests], t_width[n_tests], t_rd[n_tests],
                          t_alu[n_tests], t_rs2[n_tests], t_pc[n_tests], t_uimm[n_tests],
                          t_br[n_tests], t_exp[n_tests], t_chk[n_tests]);
            if (cnt != 15) begin
                $display("test line %s does not have the expected 15 fields", first);
                format_errors++;
            end else begin
                t_bad[n_tests] = 1'b0;
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_op(input int i);
        valid          = t_valid[i];
        load_regfile   = t_load[i];
        regfilemux_sel = t_sel[i];
        mem_read       = t_mrd[i];
        mem_write      = t_mwr[i];
        store_width    = t_width[i];
        rd             = t_rd[i];
        alu_out        = t_alu[i];
        rs2_data       = t_rs2[i];
        pc             = t_pc[i];
        u_imm          = t_uimm[i];
        br_en          = t_br[i];
    endtask

    task automatic drive_idle();
        valid          = 1'b0;
        load_regfile   = 1'b0;
        regfilemux_sel = '0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        store_width    = '0;
        rd             = '0;
        alu_out        = '0;
        rs2_data       = '0;
        pc             = '0;
        u_imm          = '0;
        br_en          = 1'b0;
    endtask

    task automatic check_value(input string name, input string what, input logic [31:0] exp,
                               input logic [31:0] act, inout bit bad);
        value_match_a: assert (act === exp) else begin
            $display("[ERROR] %s %s: expected %h, actual %h", name, what, exp, act);
            bad = 1'b1;
        end
    endtask

    task automatic finish_test(input string name, input bit bad);
        if (bad) begin
            fail_count++;
            $display("FAIL  %s", name);
        end else begin
            pass_count++;
            $display("PASS  %s", name);
        end
    endtask

    task automatic check_reset();
        bit bad;
        bad = 1'b0;
        check_value("reset", "wb_load_o", 32'd0, {31'd0, wb_load}, bad);
        for (int r = 0; r < `NUM_REGS; r++) begin
            rd_addr = r[4:0];
            #1;
            check_value("reset", $sformatf("x%0d", r), 32'd0, rd_data, bad);
        end
        finish_test("reset", bad);
    endtask

    // writeback bus one cycle after the op entered the memory register
    task automatic check_writeback(input int i);
        logic exp_load;
        exp_load = t_valid[i] & t_load[i];
        check_value(names[i], "wb_load_o", {31'd0, exp_load}, {31'd0, wb_load}, t_bad[i]);
        if (exp_load) begin
            check_value(names[i], "wb_rd_o", {27'd0, t_rd[i]}, {27'd0, wb_rd}, t_bad[i]);
            check_value(names[i], "wb_data_o", t_exp[i], wb_data, t_bad[i]);
        end
    endtask

    task automatic check_commit(input int i);
        if (t_valid[i] && t_load[i] && t_rd[i] != 5'd0) model[t_rd[i]] = t_exp[i];
        check_value(names[i], $sformatf("x%0d", t_chk[i]), model[t_chk[i]], rd_data, t_bad[i]);
        finish_test(names[i], t_bad[i]);
    endtask

    // op k is issued after edge k and commits at edge k+3 of this loop
    task automatic run_tests();
        for (int k = 0; k < n_tests + 3; k++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (k < n_tests) drive_op(k);
            else drive_idle();
            if (k >= 3) rd_addr = t_chk[k-3];
            #DRIVE_DELAY;
            if (k >= 2 && k - 2 < n_tests) check_writeback(k - 2);
            if (k >= 3) check_commit(k - 3);
        end
    endtask

    initial begin : main
        bit ok;
        drive_idle();
        // a live register write held through reset must never reach writeback
        valid         = 1'b1;
        load_regfile  = 1'b1;
        rd            = 5'd1;
        alu_out       = 32'hffff_ffff;
        rd_addr       = '0;
        pass_count    = 0;
        fail_count    = 0;
        format_errors = 0;
        for (int r = 0; r < `NUM_REGS; r++) model[r] = '0;
        load_tests(ok);
        loaded = 1'b1;
        if (!ok) begin
            $display("cannot open the test file verif/mem_wb_tests.txt");
            $display("Checks failed");
            $finish;
        end else begin
            @(negedge rst);
            drive_idle();
            @(posedge clk);
            #DRIVE_DELAY;
            check_reset();
            run_tests();
            $display("tests: %0d passed, %0d failed, %0d bad lines",
                     pass_count, fail_count, format_errors);
            if (fail_count == 0 && format_errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    initial begin : watchdog
        wait (loaded);
        #((n_tests + 10) * CLK_PERIOD * 4);
        $display("timeout: the test run did not finish in the expected time");
        $display("Checks failed");
        $finish;
    end

endmodule : rv32i_mem_wb_tb

//--- verif/tb_clock.sv
module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // reset drops just after an edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_o = 1'b0;
    end

endmodule : tb_clock

//--- source/rv32i_mem_wb.sv
`include "rv32i_consts.svh"

module rv32i_mem_wb (
    input  logic               clk_i,
    input  logic               rst_i,

    // operation from execute
    input  logic               valid_i,
    input  logic               load_regfile_i,
    input  logic [3:0]         regfilemux_sel_i,
    input  logic               mem_read_i,
    input  logic               mem_write_i,
    input  logic [1:0]         store_width_i,
    input  logic [4:0]         rd_i,
    input  logic [`XLEN-1:0]   alu_out_i,
    input  logic [`XLEN-1:0]   rs2_data_i,
    input  logic [`XLEN-1:0]   pc_i,
    input  logic [`XLEN-1:0]   u_imm_i,
    input  logic               br_en_i,

    // register read port
    input  logic [4:0]         rd_addr_i,
    output logic [`XLEN-1:0]   rd_data_o,

    // writeback bus for bypassing
    output logic               wb_load_o,
    output logic [4:0]         wb_rd_o,
    output logic [`XLEN-1:0]   wb_data_o
);
    import rv32i_types::*;

    logic                            dmem_read;
    logic [3:0]                      dmem_byte_en;
    logic [$clog2(`DMEM_WORDS)-1:0]  dmem_addr;
    mem_word_u                       dmem_wdata;
    mem_word_u                       dmem_rdata;

    logic                            wb_valid;
    logic                            wb_load_regfile;
    logic [3:0]                      wb_regfilemux_sel;
    logic [4:0]                      wb_rd;
    logic [`XLEN-1:0]                wb_alu_out;
    logic [`XLEN-1:0]                wb_pc;
    logic [`XLEN-1:0]                wb_u_imm;
    logic                            wb_br_en;

    mem_stage u_mem_stage (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .valid_i             (valid_i),
        .load_regfile_i      (load_regfile_i),
        .regfilemux_sel_i    (regfilemux_sel_i),
        .mem_read_i          (mem_read_i),
        .mem_write_i         (mem_write_i),
        .store_width_i       (store_width_i),
        .rd_i                (rd_i),
        .alu_out_i           (alu_out_i),
        .rs2_data_i          (rs2_data_i),
        .pc_i                (pc_i),
        .u_imm_i             (u_imm_i),
        .br_en_i             (br_en_i),
        .dmem_read_o         (dmem_read),
        .dmem_byte_en_o      (dmem_byte_en),
        .dmem_addr_o         (dmem_addr),
        .dmem_wdata_o        (dmem_wdata),
        .wb_valid_o          (wb_valid),
        .wb_load_regfile_o   (wb_load_regfile),
        .wb_regfilemux_sel_o (wb_regfilemux_sel),
        .wb_rd_o             (wb_rd),
        .wb_alu_out_o        (wb_alu_out),
        .wb_pc_o             (wb_pc),
        .wb_u_imm_o          (wb_u_imm),
        .wb_br_en_o          (wb_br_en)
    );

    data_mem u_data_mem (
        .clk_i          (clk_i),
        .dmem_read_i    (dmem_read),
        .dmem_byte_en_i (dmem_byte_en),
        .dmem_addr_i    (dmem_addr),
        .dmem_wdata_i   (dmem_wdata),
        .dmem_rdata_o   (dmem_rdata)
    );

    wb_stage u_wb_stage (
        .wb_valid_i       (wb_valid),
        .load_regfile_i   (wb_load_regfile),
        .regfilemux_sel_i (wb_regfilemux_sel),
        .rd_i             (wb_rd),
        .alu_out_i        (wb_alu_out),
        .pc_i             (wb_pc),
        .u_imm_i          (wb_u_imm),
        .br_en_i          (wb_br_en),
        .mem_rdata_i      (dmem_rdata),
        .load_regfile_o   (wb_load_o),
        .rd_o             (wb_rd_o),
        .regfilemux_out_o (wb_data_o)
    );

    regfile u_regfile (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .load_i    (wb_load_o),
        .rd_i      (wb_rd_o),
        .data_i    (wb_data_o),
        .rs_addr_i (rd_addr_i),
        .rs_data_o (rd_data_o)
    );

endmodule : rv32i_mem_wb

//--- source/regfile.sv
`include "rv32i_consts.svh"

module regfile (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               load_i,
    input  logic [4:0]         rd_i,
    input  logic [`XLEN-1:0]   data_i,
    input  logic [4:0]         rs_addr_i,
    output logic [`XLEN-1:0]   rs_data_o
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (load_i && rd_i != 5'd0) begin
            // x0 is never written, so it stays zero
            regs[rd_i] <= data_i;
        end
    end

    // combinational read, shows a write from the edge on
    assign rs_data_o = regs[rs_addr_i];

    // a load result with X usually means a bad lane select upstream
    write_known_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (load_i && rd_i != 5'd0) |-> !$isunknown(data_i)
    ) else $error("unknown data written to x%0d", rd_i);

endmodule : regfile

//--- source/wb_stage.sv
`include "rv32i_consts.svh"

module wb_stage (
    input  logic                    wb_valid_i,
    input  logic                    load_regfile_i,
    input  logic [3:0]              regfilemux_sel_i,
    input  logic [4:0]              rd_i,
    input  logic [`XLEN-1:0]        alu_out_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic [`XLEN-1:0]        u_imm_i,
    input  logic                    br_en_i,
    input  rv32i_types::mem_word_u  mem_rdata_i,

    output logic                    load_regfile_o,
    output logic [4:0]              rd_o,
    output logic [`XLEN-1:0]        regfilemux_out_o
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;
    logic        is_half_load;

    // lane picked by the low address bits
    assign load_byte = mem_rdata_i.bytes[alu_out_i[1:0]];
    assign load_half = mem_rdata_i.halves[alu_out_i[1]];

    assign is_half_load = (regfilemux_sel_i == `REGMUX_LH) ||
                          (regfilemux_sel_i == `REGMUX_LHU);

    always_comb begin : wb_mux
        case (regfilemux_sel_i)
            `REGMUX_ALU_OUT: begin
                regfilemux_out_o = alu_out_i;
            end
            `REGMUX_BR_EN: begin
                regfilemux_out_o = {{(`XLEN-1){1'b0}}, br_en_i};
            end
            `REGMUX_U_IMM: begin
                regfilemux_out_o = u_imm_i;
            end
            `REGMUX_PC_PLUS4: begin
                regfilemux_out_o = pc_i + `XLEN'd4;
            end
            `REGMUX_LW: begin
                regfilemux_out_o = mem_rdata_i;
            end
            `REGMUX_LH: begin
                regfilemux_out_o = {{(`XLEN-16){load_half[15]}}, load_half};
            end
            `REGMUX_LHU: begin
                regfilemux_out_o = {{(`XLEN-16){1'b0}}, load_half};
            end
            `REGMUX_LB: begin
                regfilemux_out_o = {{(`XLEN-8){load_byte[7]}}, load_byte};
            end
            `REGMUX_LBU: begin
                regfilemux_out_o = {{(`XLEN-8){1'b0}}, load_byte};
            end
            default: begin
                regfilemux_out_o = '0;
            end
        endcase
    end

    // a bubble never writes the register file
    assign load_regfile_o = wb_valid_i & load_regfile_i;
    assign rd_o           = rd_i;

    // no clock here, so these are checked at the end of each time step
    always_comb begin : wb_checks
        if (wb_valid_i) begin
            sel_known_a: assert final (!$isunknown(regfilemux_sel_i))
                else $error("unknown writeback select");
            if (is_half_load) begin
                half_aligned_a: assert final (alu_out_i[0] == 1'b0)
                    else $error("misaligned halfword load at %h", alu_out_i);
            end
        end
    end

endmodule : wb_stage

//--- source/data_mem.sv
`include "rv32i_consts.svh"

module data_mem (
    input  logic                             clk_i,
    input  logic                             dmem_read_i,
    input  logic [3:0]                       dmem_byte_en_i,
    input  logic [$clog2(`DMEM_WORDS)-1:0]   dmem_addr_i,
    input  rv32i_types::mem_word_u           dmem_wdata_i,
    output rv32i_types::mem_word_u           dmem_rdata_o
);
    import rv32i_types::*;

    mem_word_u mem [`DMEM_WORDS];
    mem_word_u merged;

    // stored word with the enabled bytes replaced
    always_comb begin : merge_bytes
        merged = mem[dmem_addr_i];
        for (int i = 0; i < 4; i++) begin
            if (dmem_byte_en_i[i]) begin
                merged.bytes[i] = dmem_wdata_i.bytes[i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < 4; i++) begin
            if (dmem_byte_en_i[i]) begin
                mem[dmem_addr_i].bytes[i] <= dmem_wdata_i.bytes[i];
            end
        end
        // read data holds until the next read
        if (dmem_read_i) begin
            dmem_rdata_o <= merged;
        end
    end

    // the memory stage issues at most one access per operation
    rw_exclusive_a: assert property (
        @(posedge clk_i) dmem_read_i |-> dmem_byte_en_i == 4'b0000
    ) else $error("read and write to data memory in the same cycle");

endmodule : data_mem

//--- source/mem_stage.sv
`include "rv32i_consts.svh"

module mem_stage (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             valid_i,
    input  logic                             load_regfile_i,
    input  logic [3:0]                       regfilemux_sel_i,
    input  logic                             mem_read_i,
    input  logic                             mem_write_i,
    input  logic [1:0]                       store_width_i,
    input  logic [4:0]                       rd_i,
    input  logic [`XLEN-1:0]                 alu_out_i,
    input  logic [`XLEN-1:0]                 rs2_data_i,
    input  logic [`XLEN-1:0]                 pc_i,
    input  logic [`XLEN-1:0]                 u_imm_i,
    input  logic                             br_en_i,

    output logic                             dmem_read_o,
    output logic [3:0]                       dmem_byte_en_o,
    output logic [$clog2(`DMEM_WORDS)-1:0]   dmem_addr_o,
    output rv32i_types::mem_word_u           dmem_wdata_o,

    output logic                             wb_valid_o,
    output logic                             wb_load_regfile_o,
    output logic [3:0]                       wb_regfilemux_sel_o,
    output logic [4:0]                       wb_rd_o,
    output logic [`XLEN-1:0]                 wb_alu_out_o,
    output logic [`XLEN-1:0]                 wb_pc_o,
    output logic [`XLEN-1:0]                 wb_u_imm_o,
    output logic                             wb_br_en_o
);
    import rv32i_types::*;

    localparam int ADDR_W = $clog2(`DMEM_WORDS);

    // memory stage register
    logic              ex_valid;
    logic              ex_load_regfile;
    logic [3:0]        ex_regfilemux_sel;
    logic              ex_mem_read;
    logic              ex_mem_write;
    logic [1:0]        ex_store_width;
    logic [4:0]        ex_rd;
    logic [`XLEN-1:0]  ex_alu_out;
    logic [`XLEN-1:0]  ex_rs2_data;
    logic [`XLEN-1:0]  ex_pc;
    logic [`XLEN-1:0]  ex_u_imm;
    logic              ex_br_en;

    mem_word_u         store_word;
    logic [3:0]        store_en;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_valid   <= 1'b0;
            wb_valid_o <= 1'b0;
        end else begin
            ex_valid   <= valid_i;
            wb_valid_o <= ex_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_load_regfile   <= load_regfile_i;
        ex_regfilemux_sel <= regfilemux_sel_i;
        ex_mem_read       <= mem_read_i;
        ex_mem_write      <= mem_write_i;
        ex_store_width    <= store_width_i;
        ex_rd             <= rd_i;
        ex_alu_out        <= alu_out_i;
        ex_rs2_data       <= rs2_data_i;
        ex_pc             <= pc_i;
        ex_u_imm          <= u_imm_i;
        ex_br_en          <= br_en_i;
    end

    // store data goes out in every lane, byte enables pick the target
    always_comb begin : store_lanes
        store_word = ex_rs2_data;
        store_en   = 4'b0000;
        case (ex_store_width)
            `STORE_B: begin
                store_word.bytes = {4{ex_rs2_data[7:0]}};
                store_en         = 4'b0001 << ex_alu_out[1:0];
            end
            `STORE_H: begin
                store_word.halves = {2{ex_rs2_data[15:0]}};
                store_en          = ex_alu_out[1] ? 4'b1100 : 4'b0011;
            end
            `STORE_W: begin
                store_en = 4'b1111;
            end
            default: begin
                store_en = 4'b0000;
            end
        endcase
    end

    assign dmem_read_o    = ex_valid & ex_mem_read;
    assign dmem_byte_en_o = (ex_valid && ex_mem_write) ? store_en : 4'b0000;
    assign dmem_addr_o    = ex_alu_out[ADDR_W+1:2];
    assign dmem_wdata_o   = store_word;

    // writeback register, no stall so it follows every cycle
    always_ff @(posedge clk_i) begin
        wb_load_regfile_o   <= ex_load_regfile;
        wb_regfilemux_sel_o <= ex_regfilemux_sel;
        wb_rd_o             <= ex_rd;
        wb_alu_out_o        <= ex_alu_out;
        wb_pc_o             <= ex_pc;
        wb_u_imm_o          <= ex_u_imm;
        wb_br_en_o          <= ex_br_en;
    end

    // misaligned stores would land in the wrong lanes
    store_aligned_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (ex_valid && ex_mem_write) |->
            (ex_store_width != `STORE_H || ex_alu_out[0] == 1'b0) &&
            (ex_store_width != `STORE_W || ex_alu_out[1:0] == 2'b00)
    ) else $error("misaligned store at address %h", ex_alu_out);

endmodule : mem_stage

//--- source/rv32i_types.sv
`include "rv32i_consts.svh"

package rv32i_types;

    // one memory word, seen as byte lanes or halfword lanes
    // lane 0 is the least significant
    typedef union packed {
        logic [`XLEN/8-1:0][7:0]   bytes;
        logic [`XLEN/16-1:0][15:0] halves;
    } mem_word_u;

endpackage : rv32i_types

//--- include/rv32i_consts.svh
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

// datapath and storage sizes
`define XLEN        32
`define NUM_REGS    32
`define DMEM_WORDS  256

// writeback result source
`define REGMUX_ALU_OUT   4'd0
`define REGMUX_BR_EN     4'd1
`define REGMUX_U_IMM     4'd2
`define REGMUX_PC_PLUS4  4'd3
`define REGMUX_LW        4'd4
`define REGMUX_LH        4'd5
`define REGMUX_LHU       4'd6
`define REGMUX_LB        4'd7
`define REGMUX_LBU       4'd8

// store width
`define STORE_B  2'd0
`define STORE_H  2'd1
`define STORE_W  2'd2

`endif
